// File: Bender.yml
package:
  name: music_player

sources:
  - files:
      - src/music_pkg.sv
      - src/note_bus_if.sv
      - src/song_rom.sv
      - src/song_reader.sv
      - src/note_player.sv
      - src/tone_gen.sv
      - src/music_apb_regs.sv
      - src/music_player.sv
  - target: simulation
    files:
      - sim/music_player_tb.sv

// File: files.f
src/music_pkg.sv
src/note_bus_if.sv
src/song_rom.sv
src/song_reader.sv
src/note_player.sv
src/tone_gen.sv
src/music_apb_regs.sv
src/music_player.sv
sim/music_player_tb.sv

// File: sim/music_player_tb.sv
`default_nettype none

module music_player_tb
    import music_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_CYCLES = 40000;
    localparam int WAIT_LIMIT = 2000;

    logic                      clk;
    logic                      rst;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [APB_DATA_WIDTH-1:0] pwdata;
    logic [APB_DATA_WIDTH-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
    logic                      note_start;
    logic [NOTE_WIDTH-1:0]     note;
    logic                      audio;

    int unsigned cycle;
    int unsigned lcg_state;
    int          err_cnt [1:6];
    int          cur_test;
    int          pass_cnt;
    int          fail_cnt;

    // Expected playback is set by the test sequence on falling edges.
    int          mon_song;
    logic        mon_ff;
    int          mon_idx;
    logic        expect_notes;
    int          starts_seen;

    logic        interval_valid;
    int unsigned last_start;
    int          prev_dur;
    logic        cur_is_rest;
    int          half_period;
    int unsigned note_end;
    logic        toggle_valid;
    int unsigned last_toggle;
    int          toggle_pairs;
    logic        audio_q;

    music_player i_music_player (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .note_start (note_start),
        .note       (note),
        .audio      (audio)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        wait (cycle >= MAX_CYCLES);
        $display("ERROR: run stopped after %0d cycles without finishing", cycle);
        $display("Some tests failed");
        $finish;
    end

    // ****************************************
    // Reference model and helpers.
    // ****************************************
    // Song entry is {activate, note, duration, 3'b000}.
    function automatic logic [ROM_DATA_WIDTH-1:0] expected_word(input int song, input int index);
        logic [NOTE_WIDTH-1:0]     n;
        logic [DURATION_WIDTH-1:0] d;
        n = NOTE_WIDTH'((song * 8 + index * 3) % 64);
        d = DURATION_WIDTH'(2 + 2 * (index % 4));
        return {(index % 7) != 6, n, d, 3'b000};
    endfunction

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    task automatic check_value(input int id, input string name, input int exp, input int got);
        assert (exp == got) else begin
            $display("CHECK FAILED at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
            err_cnt[id]++;
        end
    endtask

    task automatic report_test(input int id, input string name);
        if (err_cnt[id] == 0) begin
            pass_cnt++;
            $display("test %0d %s: passed", id, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: failed with %0d errors", id, name, err_cnt[id]);
        end
    endtask

    // One APB transfer with setup and access phases driven on falling edges.
    task automatic apb_transfer(input logic write, input logic [APB_ADDR_WIDTH-1:0] addr,
                                input logic [APB_DATA_WIDTH-1:0] wdata,
                                output logic [APB_DATA_WIDTH-1:0] rdata, output logic slverr);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #10;
        rdata  = prdata;
        slverr = pslverr;
        check_value(cur_test, "pready", 1, pready);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [APB_ADDR_WIDTH-1:0] addr,
                             input logic [APB_DATA_WIDTH-1:0] data);
        logic [APB_DATA_WIDTH-1:0] rd;
        logic                      err;
        apb_transfer(1'b1, addr, data, rd, err);
    endtask

    task automatic apb_read(input logic [APB_ADDR_WIDTH-1:0] addr,
                            output logic [APB_DATA_WIDTH-1:0] data);
        logic err;
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    task automatic wait_starts(input int target);
        int n;
        n = 0;
        while (starts_seen < target && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (starts_seen < target) begin
            $display("ERROR: only %0d note starts seen while waiting for %0d", starts_seen, target);
            err_cnt[cur_test]++;
        end
    endtask

    task automatic wait_song_done();
        logic [APB_DATA_WIDTH-1:0] rd;
        int                        n;
        n  = 0;
        rd = '0;
        while (!rd[0] && n < WAIT_LIMIT) begin
            apb_read(STATUS, rd);
            n++;
        end
        if (!rd[0]) begin
            $display("ERROR: STATUS.done was not set after %0d reads", n);
            err_cnt[cur_test]++;
        end
    endtask

    task automatic start_monitor(input int song, input logic ff_on);
        mon_song       = song;
        mon_ff         = ff_on;
        mon_idx        = 0;
        interval_valid = 1'b0;
        starts_seen    = 0;
        expect_notes   = 1'b1;
    endtask

    // ****************************************
    // Monitor and compare.
    // ****************************************
    always @(posedge clk) begin
        logic [ROM_DATA_WIDTH-1:0] w;
        int                        dur;
        if (!rst) begin
            if (cur_is_rest) begin
                assert (audio == 1'b0) else begin
                    $display("CHECK FAILED at %0t: audio expected 0 got %b", $time, audio);
                    err_cnt[(cur_test == 6) ? 6 : 5]++;
                end
            end
            // The drop to low after the note has ended is not a toggle.
            if (audio != audio_q && cycle <= note_end) begin
                if (toggle_valid) begin
                    assert (cycle - last_toggle == half_period) else begin
                        $display("CHECK FAILED at %0t: audio half period expected %0d got %0d",
                                 $time, half_period, cycle - last_toggle);
                        err_cnt[(cur_test == 6) ? 6 : 5]++;
                    end
                    toggle_pairs++;
                end
                toggle_valid = 1'b1;
                last_toggle  = cycle;
            end
            audio_q = audio;
            if (note_start) begin
                w   = expected_word(mon_song, mon_idx);
                dur = mon_ff ? int'(w[8:3]) / 2 : int'(w[8:3]);
                if (!expect_notes) begin
                    $display("ERROR at %0t: note_start pulsed while playback was stopped", $time);
                    err_cnt[cur_test]++;
                end else begin
                    assert (note == w[14:9]) else begin
                        $display("CHECK FAILED at %0t: note expected %0d got %0d (index %0d)",
                                 $time, w[14:9], note, mon_idx);
                        err_cnt[cur_test]++;
                    end
                    if (interval_valid) begin
                        assert (cycle - last_start == prev_dur * BEAT_DIV + 3) else begin
                            $display("CHECK FAILED at %0t: note_start interval expected %0d got %0d",
                                     $time, prev_dur * BEAT_DIV + 3, cycle - last_start);
                            err_cnt[(cur_test == 2) ? 3 : cur_test]++;
                        end
                    end
                end
                interval_valid = 1'b1;
                last_start     = cycle;
                prev_dur       = dur;
                cur_is_rest    = !w[15];
                half_period    = int'(w[14:9]) + TONE_BASE;
                note_end       = cycle + dur * BEAT_DIV + 1;
                toggle_valid   = 1'b0;
                mon_idx        = (mon_idx + 1) % SONG_LEN;
                starts_seen++;
            end
        end
    end

    // ****************************************
    // Tests.
    // ****************************************
    task automatic test_registers();
        logic [APB_DATA_WIDTH-1:0] rd;
        logic                      err;
        apb_write(CTRL, 32'hC);
        apb_transfer(1'b0, CTRL, '0, rd, err);
        check_value(1, "prdata", 32'hC, rd);
        check_value(1, "pslverr", 0, err);
        apb_write(CTRL, 32'h6);
        apb_read(CTRL, rd);
        check_value(1, "prdata", 32'h6, rd);
        // Unmapped address.
        apb_transfer(1'b1, 4'h8, 32'hF, rd, err);
        check_value(1, "pslverr", 1, err);
        apb_transfer(1'b0, 4'h8, '0, rd, err);
        check_value(1, "pslverr", 1, err);
        apb_read(CTRL, rd);
        check_value(1, "prdata", 32'h6, rd);
        apb_write(CTRL, 32'h0);
    endtask

    task automatic play_full_song(input int song, input logic ff_on);
        logic [APB_DATA_WIDTH-1:0] rd;
        start_monitor(song, ff_on);
        apb_write(CTRL, {28'b0, ff_on, 2'(song), 1'b1});
        wait_song_done();
        expect_notes = 1'b0;
        check_value(cur_test, "note_start count", SONG_LEN, starts_seen);
        apb_read(CTRL, rd);
        check_value(cur_test, "CTRL.play", 0, rd[0]);
        repeat (60) @(negedge clk);
    endtask

    task automatic pause_and_resume(input int song, input int pause_idx);
        start_monitor(song, 1'b0);
        apb_write(CTRL, {29'b0, 2'(song), 1'b1});
        wait_starts(pause_idx + 1);
        apb_write(CTRL, {29'b0, 2'(song), 1'b0});
        expect_notes = 1'b0;
        repeat (60) @(negedge clk);
        // Resume fetches the paused entry again.
        mon_idx        = pause_idx;
        interval_valid = 1'b0;
        expect_notes   = 1'b1;
        apb_write(CTRL, {29'b0, 2'(song), 1'b1});
        wait_starts(pause_idx + 2);
        wait_song_done();
        check_value(6, "note_start count", SONG_LEN + 1, starts_seen);
        expect_notes = 1'b0;
    endtask

    initial begin
        int song;
        int pause_idx;
        clk          = 1'b0;
        rst          = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        cycle        = 0;
        lcg_state    = 6;
        err_cnt      = '{default: 0};
        pass_cnt     = 0;
        fail_cnt     = 0;
        cur_test     = 1;
        expect_notes = 1'b0;
        cur_is_rest  = 1'b0;
        note_end     = 0;
        toggle_valid = 1'b0;
        toggle_pairs = 0;
        audio_q      = 1'b0;
        start_monitor(0, 1'b0);
        expect_notes = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        test_registers();
        report_test(1, "registers");

        cur_test = 2;
        // Songs 0 and 1 hold rests long enough to sound a tone.
        song     = lcg_next() % 2;
        play_full_song(song, 1'b0);
        report_test(2, "note sequence");
        report_test(3, "note timing");

        cur_test = 4;
        song     = lcg_next() % 4;
        play_full_song(song, 1'b1);
        report_test(4, "fast-forward");
        if (toggle_pairs == 0) begin
            $display("ERROR: no two audio toggles were seen within one note");
            err_cnt[5]++;
        end
        report_test(5, "rests and tone");

        cur_test  = 6;
        song      = lcg_next() % 4;
        pause_idx = 3 + lcg_next() % 24;
        pause_and_resume(song, pause_idx);
        report_test(6, "pause and resume");

        $display("summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/music_apb_regs.sv
`default_nettype none

module music_apb_regs
    import music_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       psel,
    input  wire                       penable,
    input  wire                       pwrite,
    input  wire  [APB_ADDR_WIDTH-1:0] paddr,
    input  wire  [APB_DATA_WIDTH-1:0] pwdata,
    input  wire                       song_done,
    input  wire  [NOTE_WIDTH-1:0]     cur_note,
    output logic [APB_DATA_WIDTH-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr,
    output logic                      play,
    output logic [SONG_SEL_WIDTH-1:0] song,
    output logic                      ff
);

    logic access;
    logic addr_ok;
    logic done;

    assign access  = psel && penable;
    assign addr_ok = (paddr == CTRL) || (paddr == STATUS);

    // No wait states.
    assign pready  = access;
    assign pslverr = access && !addr_ok;

    // ****************************************
    // Register writes.
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            play <= 1'b0;
            song <= '0;
            ff   <= 1'b0;
            done <= 1'b0;
        end else begin
            if (access && pwrite && paddr == CTRL) begin
                play <= pwdata[0];
                song <= pwdata[2:1];
                ff   <= pwdata[3];
                done <= 1'b0;
            end
            // End of song wins over a host write.
            if (song_done) begin
                play <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // Read data.
    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (paddr)
                CTRL:    prdata[3:0] = {ff, song, play};
                STATUS:  prdata = {22'b0, cur_note, 3'b000, done};
                default: prdata = '0;
            endcase
        end
    end

    a_apb_setup: assert property (@(posedge clk) disable iff (rst)
        penable |-> $past(psel));

endmodule

`default_nettype wire

// File: src/music_pkg.sv
`default_nettype none

package music_pkg;

    // ****************************************
    // Widths.
    // ****************************************
    localparam int SONG_WIDTH     = 5;
    localparam int NOTE_WIDTH     = 6;
    localparam int DURATION_WIDTH = 6;
    localparam int SONG_SEL_WIDTH = 2;
    localparam int ROM_DATA_WIDTH = 16;
    localparam int ROM_ADDR_WIDTH = SONG_SEL_WIDTH + SONG_WIDTH;
    localparam int ROM_DEPTH      = 2 ** ROM_ADDR_WIDTH;
    localparam int SONG_LEN       = 2 ** SONG_WIDTH;
    localparam int APB_ADDR_WIDTH = 4;
    localparam int APB_DATA_WIDTH = 32;

    // ****************************************
    // Timing.
    // ****************************************
    // Clock cycles per beat.
    localparam int BEAT_DIV       = 4;
    localparam int BEAT_CNT_WIDTH = $clog2(BEAT_DIV);
    // Tone half period is note + TONE_BASE cycles.
    localparam int TONE_BASE      = 4;
    localparam int TONE_CNT_WIDTH = NOTE_WIDTH + 1;

    typedef enum logic [2:0] {
        PAUSED            = 3'b000,
        WAIT              = 3'b001,
        INCREMENT_ADDRESS = 3'b010,
        RETRIEVE_NOTE     = 3'b011,
        NEW_NOTE_READY    = 3'b100
    } reader_state_e;

    typedef enum logic [APB_ADDR_WIDTH-1:0] {
        CTRL   = 4'h0,
        STATUS = 4'h4
    } reg_addr_e;

    // Word layout is {activate, note[5:0], duration[5:0], 3'b000}.
    function automatic logic [ROM_DATA_WIDTH-1:0] song_word(input int unsigned song,
                                                            input int unsigned index);
        logic [NOTE_WIDTH-1:0]     note;
        logic [DURATION_WIDTH-1:0] dur;
        logic                      act;
        note = NOTE_WIDTH'((song * 8 + index * 3) % 64);
        dur  = DURATION_WIDTH'(2 + 2 * (index % 4));
        // Every seventh entry is a rest.
        act  = (index % 7) != 6;
        return {act, note, dur, 3'b000};
    endfunction

endpackage

`default_nettype wire

// File: src/music_player.sv
`default_nettype none

module music_player
    import music_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       psel,
    input  wire                       penable,
    input  wire                       pwrite,
    input  wire  [APB_ADDR_WIDTH-1:0] paddr,
    input  wire  [APB_DATA_WIDTH-1:0] pwdata,
    output logic [APB_DATA_WIDTH-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr,
    output logic                      note_start,
    output logic [NOTE_WIDTH-1:0]     note,
    output logic                      audio
);

    logic                      play;
    logic                      ff;
    logic                      song_done;
    logic                      tone_on;
    logic [SONG_SEL_WIDTH-1:0] song;
    logic [NOTE_WIDTH-1:0]     tone_note;

    note_bus_if bus ();

    music_apb_regs i_music_apb_regs (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .song_done (song_done),
        .cur_note  (bus.note),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .play      (play),
        .song      (song),
        .ff        (ff)
    );

    // ****************************************
    // Decode, execute and tone stages.
    // ****************************************
    song_reader i_song_reader (
        .clk       (clk),
        .rst       (rst),
        .play      (play),
        .song      (song),
        .ff        (ff),
        .song_done (song_done),
        .bus       (bus.reader)
    );

    note_player i_note_player (
        .clk       (clk),
        .rst       (rst),
        .tone_note (tone_note),
        .tone_on   (tone_on),
        .bus       (bus.player)
    );

    tone_gen i_tone_gen (
        .clk       (clk),
        .rst       (rst),
        .tone_note (tone_note),
        .tone_on   (tone_on),
        .audio     (audio)
    );

    // Display taps.
    assign note_start = bus.new_note;
    assign note       = bus.note;

endmodule

`default_nettype wire

// File: src/note_bus_if.sv
`default_nettype none

// Carries one decoded note to the player and the done pulse back.
interface note_bus_if
    import music_pkg::*;
();
    logic                      new_note;
    logic [NOTE_WIDTH-1:0]     note;
    logic [DURATION_WIDTH-1:0] duration;
    logic                      activate;
    logic                      note_done;

    modport reader (
        output new_note, note, duration, activate,
        input  note_done
    );

    modport player (
        input  new_note, note, duration, activate,
        output note_done
    );
endinterface

`default_nettype wire

// File: src/note_player.sv
`default_nettype none

module note_player
    import music_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,
    output logic [NOTE_WIDTH-1:0]  tone_note,
    output logic                   tone_on,
    note_bus_if.player             bus
);

    logic [BEAT_CNT_WIDTH-1:0] beat_cnt;
    logic [DURATION_WIDTH-1:0] beats_left;
    logic                      busy;
    logic                      act_q;
    logic                      beat_end;

    assign beat_end = (beat_cnt == BEAT_CNT_WIDTH'(BEAT_DIV - 1));

    // Last cycle of the last beat.
    assign bus.note_done = busy && beat_end && (beats_left == DURATION_WIDTH'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            beat_cnt   <= '0;
            beats_left <= '0;
        end else if (bus.new_note) begin
            // Divider restarts with every note.
            busy       <= 1'b1;
            beat_cnt   <= '0;
            beats_left <= bus.duration;
        end else if (busy) begin
            beat_cnt <= beat_end ? '0 : beat_cnt + 1'b1;
            if (beat_end) begin
                beats_left <= beats_left - 1'b1;
            end
            if (bus.note_done) begin
                busy <= 1'b0;
            end
        end
    end

    // Note payload held for the tone stage.
    always_ff @(posedge clk) begin
        if (rst) begin
            tone_note <= '0;
            act_q     <= 1'b0;
        end else if (bus.new_note) begin
            tone_note <= bus.note;
            act_q     <= bus.activate;
        end
    end

    assign tone_on = busy && act_q;

    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        bus.new_note |-> !busy);

endmodule

`default_nettype wire

// File: src/song_reader.sv
`default_nettype none

module song_reader
    import music_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      play,
    input  wire [SONG_SEL_WIDTH-1:0] song,
    input  wire                      ff,
    output logic                     song_done,
    note_bus_if.reader               bus
);

    reader_state_e             state;
    reader_state_e             next;
    logic [SONG_WIDTH-1:0]     note_idx;
    logic [SONG_WIDTH-1:0]     next_idx;
    logic                      overflow;
    logic [ROM_DATA_WIDTH-1:0] rom_out;
    logic [DURATION_WIDTH-1:0] dur_raw;

    song_rom i_song_rom (
        .clk  (clk),
        .addr ({song, note_idx}),
        .dout (rom_out)
    );

    // ****************************************
    // Playback FSM.
    // ****************************************
    always_comb begin
        case (state)
            PAUSED:            next = play ? RETRIEVE_NOTE : PAUSED;
            RETRIEVE_NOTE:     next = play ? NEW_NOTE_READY : PAUSED;
            NEW_NOTE_READY:    next = play ? WAIT : PAUSED;
            WAIT:              next = !play ? PAUSED
                                            : bus.note_done ? INCREMENT_ADDRESS : WAIT;
            INCREMENT_ADDRESS: next = (play && !overflow) ? RETRIEVE_NOTE : PAUSED;
            default:           next = PAUSED;
        endcase
    end

    // Index moves only in INCREMENT_ADDRESS; the carry marks the end of the song.
    assign {overflow, next_idx} = (state == INCREMENT_ADDRESS) ? {1'b0, note_idx} + 1'b1
                                                               : {1'b0, note_idx};

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= PAUSED;
            note_idx <= '0;
        end else begin
            state    <= next;
            note_idx <= next_idx;
        end
    end

    // ****************************************
    // Word decode.
    // ****************************************
    assign dur_raw = rom_out[8:3];

    assign bus.new_note = (state == NEW_NOTE_READY);
    assign bus.note     = rom_out[14:9];
    assign bus.activate = rom_out[15];
    // Fast-forward plays each note for half its length.
    assign bus.duration = ff ? dur_raw >> 1 : dur_raw;
    assign song_done    = overflow;

    a_state_legal: assert property (@(posedge clk) disable iff (rst)
        state inside {PAUSED, RETRIEVE_NOTE, NEW_NOTE_READY, WAIT, INCREMENT_ADDRESS});

    a_new_note_pulse: assert property (@(posedge clk) disable iff (rst)
        bus.new_note |=> !bus.new_note);

endmodule

`default_nettype wire

// File: src/song_rom.sv
`default_nettype none

module song_rom
    import music_pkg::*;
(
    input  wire                       clk,
    input  wire  [ROM_ADDR_WIDTH-1:0] addr,
    output logic [ROM_DATA_WIDTH-1:0] dout
);

    logic [ROM_DATA_WIDTH-1:0] rom_table [ROM_DEPTH];

    // Upper address bits pick the song, lower bits the entry.
    for (genvar i = 0; i < ROM_DEPTH; i++) begin : g_fill
        assign rom_table[i] = song_word(i / SONG_LEN, i % SONG_LEN);
    end

    // Registered read with data one cycle after the address.
    always_ff @(posedge clk) begin
        dout <= rom_table[addr];
    end

endmodule

`default_nettype wire

// File: src/tone_gen.sv
`default_nettype none

module tone_gen
    import music_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire  [NOTE_WIDTH-1:0] tone_note,
    input  wire                   tone_on,
    output logic                  audio
);

    logic [TONE_CNT_WIDTH-1:0] cnt;
    logic [TONE_CNT_WIDTH-1:0] half_period;

    assign half_period = TONE_CNT_WIDTH'(tone_note) + TONE_CNT_WIDTH'(TONE_BASE);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt   <= '0;
            audio <= 1'b0;
        end else if (!tone_on) begin
            // Rest or gap between notes.
            cnt   <= '0;
            audio <= 1'b0;
        end else if (cnt == half_period - 1'b1) begin
            cnt   <= '0;
            audio <= ~audio;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire
